// File: Makefile
TOP := tb_line_axi_bridge

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
		-f line_axi_bridge.f --Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hdl/axi_burst_master.sv
`timescale 1ns/100ps

module axi_burst_master import line_axi_pkg::*; #(
    parameter int LINE_WORDS = DEF_LINE_WORDS
) (
    input  logic  aclk,
    input  logic  rst,
    burst_if.eng  bus,
    // read address and data
    output addr_t araddr_o,
    output logic  arvalid_o,
    input  logic  arready_i,
    input  word_t rdata_i,
    input  logic  rlast_i,
    input  logic  rvalid_i,
    output logic  rready_o,
    // write address, data and response
    output addr_t awaddr_o,
    output logic  awvalid_o,
    input  logic  awready_i,
    output word_t wdata_o,
    output logic  wlast_o,
    output logic  wvalid_o,
    input  logic  wready_i,
    input  logic  bvalid_i,
    output logic  bready_o
);

    master_state_e            state;
    logic                     rd_start, line_full;
    logic                     load, w_done;
    logic                     done_q;
    logic [LINE_WORDS*32-1:0] rd_line;

    assign araddr_o  = bus.addr;    // arbiter holds it for the whole burst
    assign awaddr_o  = bus.addr;
    assign arvalid_o = (state == ST_AR);
    assign awvalid_o = (state == ST_AW);
    assign bready_o  = (state == ST_B);

    assign rd_start = (state == ST_AR) & arready_i;
    assign load     = (state == ST_AW) & awready_i;

    assign bus.done  = done_q;
    assign bus.rline = rd_line;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state  <= ST_IDLE;
            done_q <= 1'b0;
        end else begin
            done_q <= ((state == ST_R) & line_full) | ((state == ST_B) & bvalid_i);
            case (state)
                ST_IDLE: begin
                    if (bus.start) begin
                        state <= (bus.kind == BURST_DATA_WR) ? ST_AW : ST_AR;
                    end
                end
                ST_AR: if (arready_i) state <= ST_R;
                ST_R:  if (line_full) state <= ST_IDLE;
                ST_AW: if (awready_i) state <= ST_W;
                ST_W:  if (w_done) state <= ST_B;
                ST_B:  if (bvalid_i) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    line_read_assembler #(
        .LINE_WORDS (LINE_WORDS)
    ) u_rd_asm (
        .aclk        (aclk),
        .rst         (rst),
        .rd_start_i  (rd_start),
        .rdata_i     (rdata_i),
        .rvalid_i    (rvalid_i),
        .rlast_i     (rlast_i),
        .rready_o    (rready_o),
        .line_o      (rd_line),
        .line_full_o (line_full)
    );

    line_write_serializer #(
        .LINE_WORDS (LINE_WORDS)
    ) u_wr_ser (
        .aclk     (aclk),
        .rst      (rst),
        .load_i   (load),
        .line_i   (bus.wline),
        .wdata_o  (wdata_o),
        .wvalid_o (wvalid_o),
        .wlast_o  (wlast_o),
        .wready_i (wready_i),
        .w_done_o (w_done)
    );

endmodule

// File: hdl/burst_if.sv
`timescale 1ns/100ps

interface burst_if import line_axi_pkg::*; #(
    parameter int LINE_WORDS = DEF_LINE_WORDS
);

    logic                     start;    // one-cycle grant strobe
    burst_kind_e              kind;
    addr_t                    addr;     // line base
    logic [LINE_WORDS*32-1:0] wline;
    logic                     done;     // one-cycle end of burst
    logic [LINE_WORDS*32-1:0] rline;    // valid with done on reads

    modport arb (
        output start,
        output kind,
        output addr,
        output wline,
        input  done,
        input  rline
    );

    modport eng (
        input  start,
        input  kind,
        input  addr,
        input  wline,
        output done,
        output rline
    );

endinterface

// File: hdl/line_axi_bridge.sv
`timescale 1ns/100ps

module line_axi_bridge import line_axi_pkg::*; #(
    parameter int LINE_WORDS = DEF_LINE_WORDS
) (
    input  logic                     aclk,
    input  logic                     rst,
    // instruction cache
    input  logic                     inst_rd_req_i,
    input  addr_t                    inst_rd_addr_i,
    output logic                     inst_ret_valid_o,
    output logic [LINE_WORDS*32-1:0] inst_ret_line_o,
    // data cache
    input  logic                     data_rd_req_i,
    input  addr_t                    data_rd_addr_i,
    output logic                     data_ret_valid_o,
    output logic [LINE_WORDS*32-1:0] data_ret_line_o,
    input  logic                     data_wr_req_i,
    input  addr_t                    data_wr_addr_i,
    input  logic [LINE_WORDS*32-1:0] data_wr_line_i,
    output logic                     data_wr_done_o,
    // AXI read
    output addr_t                    araddr_o,
    output logic                     arvalid_o,
    input  logic                     arready_i,
    input  word_t                    rdata_i,
    input  logic                     rlast_i,
    input  logic                     rvalid_i,
    output logic                     rready_o,
    // AXI write
    output addr_t                    awaddr_o,
    output logic                     awvalid_o,
    input  logic                     awready_i,
    output word_t                    wdata_o,
    output logic                     wlast_o,
    output logic                     wvalid_o,
    input  logic                     wready_i,
    input  logic                     bvalid_i,
    output logic                     bready_o
);

    burst_if #(.LINE_WORDS(LINE_WORDS)) bus ();

    line_req_arbiter #(
        .LINE_WORDS (LINE_WORDS)
    ) u_arb (
        .aclk             (aclk),
        .rst              (rst),
        .inst_rd_req_i    (inst_rd_req_i),
        .inst_rd_addr_i   (inst_rd_addr_i),
        .data_rd_req_i    (data_rd_req_i),
        .data_rd_addr_i   (data_rd_addr_i),
        .data_wr_req_i    (data_wr_req_i),
        .data_wr_addr_i   (data_wr_addr_i),
        .data_wr_line_i   (data_wr_line_i),
        .inst_ret_valid_o (inst_ret_valid_o),
        .inst_ret_line_o  (inst_ret_line_o),
        .data_ret_valid_o (data_ret_valid_o),
        .data_ret_line_o  (data_ret_line_o),
        .data_wr_done_o   (data_wr_done_o),
        .bus              (bus.arb)
    );

    axi_burst_master #(
        .LINE_WORDS (LINE_WORDS)
    ) u_master (
        .aclk      (aclk),
        .rst       (rst),
        .bus       (bus.eng),
        .araddr_o  (araddr_o),
        .arvalid_o (arvalid_o),
        .arready_i (arready_i),
        .rdata_i   (rdata_i),
        .rlast_i   (rlast_i),
        .rvalid_i  (rvalid_i),
        .rready_o  (rready_o),
        .awaddr_o  (awaddr_o),
        .awvalid_o (awvalid_o),
        .awready_i (awready_i),
        .wdata_o   (wdata_o),
        .wlast_o   (wlast_o),
        .wvalid_o  (wvalid_o),
        .wready_i  (wready_i),
        .bvalid_i  (bvalid_i),
        .bready_o  (bready_o)
    );

endmodule

// File: hdl/line_axi_pkg.sv
package line_axi_pkg;

    // byte address and one data beat
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // beats per cache line
    localparam int DEF_LINE_WORDS = 8;

    // fixed burst shape on both address channels
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;    // 4 bytes per beat

    // which cache source a granted burst belongs to
    typedef enum logic [1:0] {
        BURST_INST_RD = 2'd0,
        BURST_DATA_RD = 2'd1,
        BURST_DATA_WR = 2'd2
    } burst_kind_e;

    // burst engine FSM
    typedef enum logic [2:0] {
        ST_IDLE = 3'd0,
        ST_AR   = 3'd1,    // read address out
        ST_R    = 3'd2,    // collecting beats
        ST_AW   = 3'd3,    // write address out
        ST_W    = 3'd4,    // beats going out
        ST_B    = 3'd5     // waiting for write response
    } master_state_e;

endpackage

// File: hdl/line_read_assembler.sv
`timescale 1ns/100ps

module line_read_assembler import line_axi_pkg::*; #(
    parameter int LINE_WORDS = DEF_LINE_WORDS
) (
    input  logic                     aclk,
    input  logic                     rst,
    input  logic                     rd_start_i,
    input  word_t                    rdata_i,
    input  logic                     rvalid_i,
    input  logic                     rlast_i,
    output logic                     rready_o,
    output logic [LINE_WORDS*32-1:0] line_o,
    output logic                     line_full_o
);

    localparam int LINE_BITS = LINE_WORDS * 32;

    logic                 rd_hs;
    logic [LINE_BITS-1:0] line_q;

    assign rd_hs  = rvalid_i & rready_o;
    assign line_o = line_q;

    always_ff @(posedge aclk) begin
        if (rst) begin
            rready_o    <= 1'b0;
            line_full_o <= 1'b0;
        end else begin
            line_full_o <= rd_hs & rlast_i;
            if (rd_start_i) rready_o <= 1'b1;
            else if (rd_hs & rlast_i) rready_o <= 1'b0;
        end
    end

    // new beat enters at the top, so word 0 ends up in the low bits
    always_ff @(posedge aclk) begin
        if (rd_hs) begin
            line_q <= {rdata_i, line_q[LINE_BITS-1:32]};
        end
    end

endmodule

// File: hdl/line_req_arbiter.sv
`timescale 1ns/100ps

module line_req_arbiter import line_axi_pkg::*; #(
    parameter int LINE_WORDS = DEF_LINE_WORDS
) (
    input  logic                     aclk,
    input  logic                     rst,
    input  logic                     inst_rd_req_i,
    input  addr_t                    inst_rd_addr_i,
    input  logic                     data_rd_req_i,
    input  addr_t                    data_rd_addr_i,
    input  logic                     data_wr_req_i,
    input  addr_t                    data_wr_addr_i,
    input  logic [LINE_WORDS*32-1:0] data_wr_line_i,
    output logic                     inst_ret_valid_o,
    output logic [LINE_WORDS*32-1:0] inst_ret_line_o,
    output logic                     data_ret_valid_o,
    output logic [LINE_WORDS*32-1:0] data_ret_line_o,
    output logic                     data_wr_done_o,
    burst_if.arb                     bus
);

    localparam int    LINE_BITS = LINE_WORDS * 32;
    localparam addr_t LINE_MASK = addr_t'(LINE_WORDS * 4 - 1);

    logic                 pend_ird, pend_drd, pend_wr;
    addr_t                ird_addr_q, drd_addr_q, wr_addr_q;
    logic [LINE_BITS-1:0] wr_line_q;
    logic                 busy, start_q;
    burst_kind_e          kind_q;
    addr_t                addr_q;
    logic                 done_ird, done_drd, done_wr;
    logic                 elig_ird, elig_drd, elig_wr;
    logic                 free, take_ird, take_drd, take_wr;

    assign done_ird = bus.done & (kind_q == BURST_INST_RD);
    assign done_drd = bus.done & (kind_q == BURST_DATA_RD);
    assign done_wr  = bus.done & (kind_q == BURST_DATA_WR);

    // the slot finishing this cycle is not eligible again
    assign elig_ird = pend_ird & ~done_ird;
    assign elig_drd = pend_drd & ~done_drd;
    assign elig_wr  = pend_wr & ~done_wr;

    assign free     = ~busy | bus.done;
    assign take_wr  = free & elig_wr;
    assign take_drd = free & ~elig_wr & elig_drd;
    assign take_ird = free & ~elig_wr & ~elig_drd & elig_ird;

    assign bus.start = start_q;
    assign bus.kind  = kind_q;
    assign bus.addr  = addr_q;
    assign bus.wline = wr_line_q;

    always_ff @(posedge aclk) begin
        if (rst) begin
            pend_ird <= 1'b0;
            pend_drd <= 1'b0;
            pend_wr  <= 1'b0;
        end else begin
            if (inst_rd_req_i) pend_ird <= 1'b1;
            else if (done_ird) pend_ird <= 1'b0;
            if (data_rd_req_i) pend_drd <= 1'b1;
            else if (done_drd) pend_drd <= 1'b0;
            if (data_wr_req_i) pend_wr <= 1'b1;
            else if (done_wr) pend_wr <= 1'b0;
        end
    end

    // request payloads, aligned to the line base
    always_ff @(posedge aclk) begin
        if (inst_rd_req_i) ird_addr_q <= inst_rd_addr_i & ~LINE_MASK;
        if (data_rd_req_i) drd_addr_q <= data_rd_addr_i & ~LINE_MASK;
        if (data_wr_req_i) begin
            wr_addr_q <= data_wr_addr_i & ~LINE_MASK;
            wr_line_q <= data_wr_line_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            busy    <= 1'b0;
            start_q <= 1'b0;
            kind_q  <= BURST_INST_RD;
            addr_q  <= '0;
        end else begin
            start_q <= take_wr | take_drd | take_ird;
            if (take_wr) begin
                kind_q <= BURST_DATA_WR;
                addr_q <= wr_addr_q;
            end else if (take_drd) begin
                kind_q <= BURST_DATA_RD;
                addr_q <= drd_addr_q;
            end else if (take_ird) begin
                kind_q <= BURST_INST_RD;
                addr_q <= ird_addr_q;
            end
            if (take_wr | take_drd | take_ird) busy <= 1'b1;
            else if (bus.done) busy <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            inst_ret_valid_o <= 1'b0;
            data_ret_valid_o <= 1'b0;
            data_wr_done_o   <= 1'b0;
        end else begin
            inst_ret_valid_o <= done_ird;
            data_ret_valid_o <= done_drd;
            data_wr_done_o   <= done_wr;
        end
    end

    always_ff @(posedge aclk) begin
        if (done_ird) inst_ret_line_o <= bus.rline;
        if (done_drd) data_ret_line_o <= bus.rline;
    end

endmodule

// File: hdl/line_write_serializer.sv
`timescale 1ns/100ps

module line_write_serializer import line_axi_pkg::*; #(
    parameter int LINE_WORDS = DEF_LINE_WORDS
) (
    input  logic                     aclk,
    input  logic                     rst,
    input  logic                     load_i,
    input  logic [LINE_WORDS*32-1:0] line_i,
    output word_t                    wdata_o,
    output logic                     wvalid_o,
    output logic                     wlast_o,
    input  logic                     wready_i,
    output logic                     w_done_o
);

    localparam int LINE_BITS = LINE_WORDS * 32;
    localparam int CW        = $clog2(LINE_WORDS);

    logic [LINE_BITS-1:0] line_q;
    logic [CW-1:0]        beat;
    logic                 last_beat;
    logic                 wr_hs;

    assign last_beat = (beat == CW'(LINE_WORDS - 1));
    assign wr_hs     = wvalid_o & wready_i;
    assign wdata_o   = line_q[beat*32 +: 32];
    assign wlast_o   = wvalid_o & last_beat;

    always_ff @(posedge aclk) begin
        if (rst) begin
            wvalid_o <= 1'b0;
            w_done_o <= 1'b0;
            beat     <= '0;
        end else begin
            w_done_o <= wr_hs & last_beat;
            if (load_i) begin
                wvalid_o <= 1'b1;
                beat     <= '0;
            end else if (wr_hs) begin
                if (last_beat) begin
                    wvalid_o <= 1'b0;
                end else begin
                    beat <= beat + 1'b1;
                end
            end
        end
    end

    // line held for the whole burst
    always_ff @(posedge aclk) begin
        if (load_i) line_q <= line_i;
    end

endmodule

// File: line_axi_bridge.f
hdl/line_axi_pkg.sv
hdl/burst_if.sv
hdl/line_req_arbiter.sv
hdl/line_read_assembler.sv
hdl/line_write_serializer.sv
hdl/axi_burst_master.sv
hdl/line_axi_bridge.sv
test/axi_mem_model.sv
test/tb_line_axi_bridge.sv

// File: test/axi_mem_model.sv
`timescale 1ns/100ps

module axi_mem_model import line_axi_pkg::*; #(
    parameter int LINE_WORDS = DEF_LINE_WORDS
) (
    input  logic  aclk,
    input  logic  rst,
    input  addr_t araddr_i,
    input  logic  arvalid_i,
    output logic  arready_o,
    output word_t rdata_o,
    output logic  rlast_o,
    output logic  rvalid_o,
    input  logic  rready_i,
    input  addr_t awaddr_i,
    input  logic  awvalid_i,
    output logic  awready_o,
    input  word_t wdata_i,
    input  logic  wlast_i,
    input  logic  wvalid_i,
    output logic  wready_o,
    output logic  bvalid_o,
    input  logic  bready_i
);

    localparam addr_t BEAT_BYTES = addr_t'(1 << AXI_SIZE_WORD);

    integer      seed;
    word_t       mem [addr_t];
    logic [31:0] rnd;
    logic        in_rst, ar_hs, r_hs, aw_hs, w_hs, b_hs;
    logic        rd_busy, wr_busy, b_wait;
    addr_t       rd_addr, wr_addr;
    int          rd_cnt, b_delay;

    // untouched words hold their own address xor a marker
    function automatic word_t read_word(addr_t a);
        return mem.exists(a) ? mem[a] : (a ^ 32'h5a5a_0000);
    endfunction

    function automatic addr_t next_addr(addr_t a, logic [1:0] burst);
        return (burst == AXI_BURST_INCR) ? a + BEAT_BYTES : a;
    endfunction

    // ready or valid held back about one cycle in four
    function automatic logic coin();
        logic [31:0] r;
        r = $random(seed);
        return r[1:0] != 2'b00;
    endfunction

    initial begin
        seed      = 32'hbbcb32cb;
        arready_o = 1'b0;
        rdata_o   = '0;
        rlast_o   = 1'b0;
        rvalid_o  = 1'b0;
        awready_o = 1'b0;
        wready_o  = 1'b0;
        bvalid_o  = 1'b0;
        rd_busy   = 1'b0;
        wr_busy   = 1'b0;
        b_wait    = 1'b0;
        rd_addr   = '0;
        wr_addr   = '0;
        rd_cnt    = 0;
        b_delay   = 0;
        forever begin
            @(posedge aclk);
            in_rst = rst;
            ar_hs  = arvalid_i & arready_o;
            r_hs   = rvalid_o & rready_i;
            aw_hs  = awvalid_i & awready_o;
            w_hs   = wvalid_i & wready_o;
            b_hs   = bvalid_o & bready_i;
            if (in_rst) begin
                rd_busy = 1'b0;
                wr_busy = 1'b0;
                b_wait  = 1'b0;
            end else begin
                if (ar_hs) begin
                    rd_busy = 1'b1;
                    rd_addr = araddr_i;
                    rd_cnt  = 0;
                end
                if (r_hs) begin
                    if (rlast_o) rd_busy = 1'b0;
                    rd_cnt++;
                    rd_addr = next_addr(rd_addr, AXI_BURST_INCR);
                end
                if (aw_hs) begin
                    wr_busy = 1'b1;
                    wr_addr = awaddr_i;
                end
                if (w_hs) begin
                    mem[wr_addr] = wdata_i;
                    wr_addr = next_addr(wr_addr, AXI_BURST_INCR);
                    if (wlast_i) begin
                        b_wait  = 1'b1;
                        rnd     = $random(seed);
                        b_delay = int'(rnd[1:0]);
                    end
                end
                if (b_hs) wr_busy = 1'b0;
            end
            #1;
            if (in_rst) begin
                arready_o = 1'b0;
                rvalid_o  = 1'b0;
                rlast_o   = 1'b0;
                awready_o = 1'b0;
                wready_o  = 1'b0;
                bvalid_o  = 1'b0;
            end else begin
                arready_o = !rd_busy && coin();
                if (r_hs) begin
                    rvalid_o = 1'b0;
                    rlast_o  = 1'b0;
                end
                if (rd_busy && !rvalid_o && coin()) begin
                    rvalid_o = 1'b1;
                    rdata_o  = read_word(rd_addr);
                    rlast_o  = (rd_cnt == LINE_WORDS - 1);
                end
                awready_o = !wr_busy && coin();
                wready_o  = wr_busy && !b_wait && !bvalid_o && coin();
                if (b_hs) bvalid_o = 1'b0;
                if (b_wait) begin
                    if (b_delay == 0) begin
                        bvalid_o = 1'b1;
                        b_wait   = 1'b0;
                    end else begin
                        b_delay--;    // response latency
                    end
                end
            end
        end
    end

endmodule

// File: test/tb_line_axi_bridge.sv
`timescale 1ns/100ps

module tb_line_axi_bridge import line_axi_pkg::*; #(
    parameter int LINE_WORDS = DEF_LINE_WORDS
);

    localparam int LINE_BITS = LINE_WORDS * 32;
    localparam int N_INST    = 20;
    localparam int N_WR      = 12;
    localparam int N_MIX     = 6;
    localparam int N_REQ     = N_INST + 2 * N_WR + 3 * N_MIX;

    logic                 aclk = 1'b0;
    logic                 rst;
    logic                 inst_rd_req_i, data_rd_req_i, data_wr_req_i;
    addr_t                inst_rd_addr_i, data_rd_addr_i, data_wr_addr_i;
    logic [LINE_BITS-1:0] data_wr_line_i, inst_ret_line_o, data_ret_line_o;
    logic                 inst_ret_valid_o, data_ret_valid_o, data_wr_done_o;
    addr_t                araddr_o, awaddr_o;
    logic                 arvalid_o, arready_i, rlast_i, rvalid_i, rready_o;
    logic                 awvalid_o, awready_i, wlast_o, wvalid_o, wready_i;
    logic                 bvalid_i, bready_o;
    word_t                rdata_i, wdata_o;

    integer               seed;
    int                   errors, checks, proto_errs, wr_bursts, w_cnt;
    int                   inst_reqs, data_reqs, wr_reqs, inst_rets, data_rets, wr_rets;
    logic [LINE_BITS-1:0] exp_inst, exp_data, exp_wline;
    word_t                shadow [addr_t];
    logic                 ar_wait, aw_wait, rd_open, order_check, aw_seen;
    addr_t                ar_last, aw_last;

    line_axi_bridge #(.LINE_WORDS(LINE_WORDS)) UUT (.*);

    axi_mem_model #(
        .LINE_WORDS (LINE_WORDS)
    ) u_mem (
        .aclk      (aclk),
        .rst       (rst),
        .araddr_i  (araddr_o),
        .arvalid_i (arvalid_o),
        .arready_o (arready_i),
        .rdata_o   (rdata_i),
        .rlast_o   (rlast_i),
        .rvalid_o  (rvalid_i),
        .rready_i  (rready_o),
        .awaddr_i  (awaddr_o),
        .awvalid_i (awvalid_o),
        .awready_o (awready_i),
        .wdata_i   (wdata_o),
        .wlast_i   (wlast_o),
        .wvalid_i  (wvalid_o),
        .wready_o  (wready_i),
        .bvalid_o  (bvalid_i),
        .bready_i  (bready_o)
    );

    always #5 aclk = ~aclk;

    function automatic word_t shadow_word(addr_t a);
        return shadow.exists(a) ? shadow[a] : (a ^ 32'h5a5a_0000);
    endfunction

    function automatic addr_t line_base(addr_t a);
        return a & ~addr_t'(LINE_WORDS * 4 - 1);
    endfunction

    function automatic logic [LINE_BITS-1:0] shadow_line(addr_t a);
        logic [LINE_BITS-1:0] line;
        for (int i = 0; i < LINE_WORDS; i++) begin
            line[i*32 +: 32] = shadow_word(line_base(a) + addr_t'(4 * i));
        end
        return line;
    endfunction

    // writes land in the shadow first, so reads issued with them see new data
    task automatic send_requests(input logic do_wr, input logic do_drd, input logic do_ird,
                                 input addr_t wr_a, input addr_t drd_a, input addr_t ird_a,
                                 input logic [LINE_BITS-1:0] wline);
        @(posedge aclk);
        #1;
        if (do_wr) begin
            for (int i = 0; i < LINE_WORDS; i++) begin
                shadow[line_base(wr_a) + addr_t'(4 * i)] = wline[i*32 +: 32];
            end
            exp_wline      = wline;
            data_wr_req_i  = 1'b1;
            data_wr_addr_i = wr_a;
            data_wr_line_i = wline;
            wr_reqs++;
        end
        if (do_drd) begin
            exp_data       = shadow_line(drd_a);
            data_rd_req_i  = 1'b1;
            data_rd_addr_i = drd_a;
            data_reqs++;
        end
        if (do_ird) begin
            exp_inst       = shadow_line(ird_a);
            inst_rd_req_i  = 1'b1;
            inst_rd_addr_i = ird_a;
            inst_reqs++;
        end
        @(posedge aclk);
        #1;
        inst_rd_req_i = 1'b0;
        data_rd_req_i = 1'b0;
        data_wr_req_i = 1'b0;
    endtask

    task automatic wait_returns();
        while (inst_rets != inst_reqs || data_rets != data_reqs || wr_rets != wr_reqs) begin
            @(posedge aclk);
            #1;
        end
    endtask

    // return pulses and AXI port rules
    always @(posedge aclk) begin
        if (!rst) begin
            if (inst_ret_valid_o) begin
                inst_rets++;
                checks++;
                if (inst_rets > inst_reqs) begin
                    errors++;
                    $display("%0t: extra inst_ret_valid_o pulse with no request open", $time);
                end else if (inst_ret_line_o !== exp_inst) begin
                    errors++;
                    $display("ERR %0t inst_ret_line_o expected %h got %h", $time,
                             exp_inst, inst_ret_line_o);
                end
            end
            if (data_ret_valid_o) begin
                data_rets++;
                checks++;
                if (data_rets > data_reqs) begin
                    errors++;
                    $display("%0t: extra data_ret_valid_o pulse with no request open", $time);
                end else if (data_ret_line_o !== exp_data) begin
                    errors++;
                    $display("ERR %0t data_ret_line_o expected %h got %h", $time,
                             exp_data, data_ret_line_o);
                end
            end
            if (data_wr_done_o) begin
                wr_rets++;
                if (wr_rets > wr_reqs) begin
                    errors++;
                    $display("%0t: extra data_wr_done_o pulse with no write open", $time);
                end
            end
            if (ar_wait && arvalid_o !== 1'b1) begin
                proto_errs++;
                $display("%0t: arvalid_o dropped before arready_i", $time);
            end else if (ar_wait && araddr_o !== ar_last) begin
                proto_errs++;
                $display("ERR %0t araddr_o expected %h got %h", $time, ar_last, araddr_o);
            end
            if (aw_wait && awvalid_o !== 1'b1) begin
                proto_errs++;
                $display("%0t: awvalid_o dropped before awready_i", $time);
            end else if (aw_wait && awaddr_o !== aw_last) begin
                proto_errs++;
                $display("ERR %0t awaddr_o expected %h got %h", $time, aw_last, awaddr_o);
            end
            ar_wait = arvalid_o && !arready_i;
            ar_last = araddr_o;
            aw_wait = awvalid_o && !awready_i;
            aw_last = awaddr_o;
            if (wvalid_o && wready_i) begin
                if (wdata_o !== exp_wline[w_cnt*32 +: 32]) begin
                    proto_errs++;
                    $display("ERR %0t wdata_o expected %h got %h", $time,
                             exp_wline[w_cnt*32 +: 32], wdata_o);
                end
                if (wlast_o !== (w_cnt == LINE_WORDS - 1)) begin
                    proto_errs++;
                    $display("ERR %0t wlast_o expected %b got %b", $time,
                             w_cnt == LINE_WORDS - 1, wlast_o);
                end
                w_cnt = (w_cnt == LINE_WORDS - 1) ? 0 : w_cnt + 1;
            end
            if (bvalid_i && bready_o) begin
                wr_bursts++;
                if (w_cnt != 0) begin
                    proto_errs++;
                    $display("%0t: write response before the last W beat", $time);
                end
            end
            if (rready_o && !rd_open) begin
                proto_errs++;
                $display("%0t: rready_o high outside a read burst", $time);
            end
            if (arvalid_o && arready_i) rd_open = 1'b1;
            if (rvalid_i && rready_o && rlast_i) rd_open = 1'b0;
            if (order_check) begin
                if (awvalid_o) aw_seen = 1'b1;
                if (arvalid_o && !aw_seen) begin
                    proto_errs++;
                    $display("%0t: arvalid_o came before awvalid_o", $time);
                end
            end
        end
    end

    initial begin
        repeat (N_REQ * 200) @(posedge aclk);
        $display("timeout: returns stopped after %0d cycles", N_REQ * 200);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0]          rnd;
        logic [LINE_BITS-1:0] wline;
        addr_t                a, c;
        int                   base_err;
        seed           = 32'hbbcb32cb;
        rst            = 1'b1;
        inst_rd_req_i  = 1'b0;
        data_rd_req_i  = 1'b0;
        data_wr_req_i  = 1'b0;
        inst_rd_addr_i = '0;
        data_rd_addr_i = '0;
        data_wr_addr_i = '0;
        data_wr_line_i = '0;
        {errors, checks, proto_errs, wr_bursts, w_cnt} = '0;
        {inst_reqs, data_reqs, wr_reqs, inst_rets, data_rets, wr_rets} = '0;
        {ar_wait, aw_wait, rd_open, order_check, aw_seen} = '0;
        ar_last = '0;
        aw_last = '0;
        exp_inst = '0;
        exp_data = '0;
        exp_wline = '0;

        for (int i = 0; i < 10; i++) begin
            @(posedge aclk);
            #1;
            checks++;
            if ({arvalid_o, awvalid_o, wvalid_o, rready_o, bready_o, inst_ret_valid_o,
                 data_ret_valid_o, data_wr_done_o} !== 8'h00) begin
                errors++;
                $display("ERR %0t idle outputs expected %h got %b", $time, 8'h00,
                         {arvalid_o, awvalid_o, wvalid_o, rready_o, bready_o,
                          inst_ret_valid_o, data_ret_valid_o, data_wr_done_o});
            end
        end
        rst = 1'b0;
        $display("test 1 reset: %0d errors", errors);

        base_err = errors;
        for (int i = 0; i < N_INST; i++) begin
            rnd = $random(seed);
            a   = rnd & 32'h0000_0fff;
            repeat (rnd[15:14]) @(posedge aclk);    // idle gap
            send_requests(1'b0, 1'b0, 1'b1, '0, '0, a, '0);
            wait_returns();
        end
        $display("test 2 inst reads: %0d requests, %0d errors", N_INST, errors - base_err);

        base_err = errors;
        for (int i = 0; i < N_WR; i++) begin
            rnd = $random(seed);
            a   = rnd & 32'h0000_0fff;
            for (int k = 0; k < LINE_WORDS; k++) wline[k*32 +: 32] = $random(seed);
            send_requests(1'b1, 1'b0, 1'b0, a, '0, '0, wline);
            wait_returns();
            rnd = $random(seed);
            c   = line_base(a) | (rnd & addr_t'(LINE_WORDS * 4 - 1));
            send_requests(1'b0, 1'b1, 1'b0, '0, c, '0, '0);
            wait_returns();
        end
        $display("test 3 write then read: %0d pairs, %0d errors", N_WR, errors - base_err);

        base_err = errors;
        for (int i = 0; i < N_MIX; i++) begin
            rnd = $random(seed);
            a   = rnd & 32'h0000_0fff;
            rnd = $random(seed);
            c   = rnd & 32'h0000_0fff;
            for (int k = 0; k < LINE_WORDS; k++) wline[k*32 +: 32] = $random(seed);
            aw_seen     = 1'b0;
            order_check = 1'b1;
            send_requests(1'b1, 1'b1, 1'b1, a, a, c, wline);
            wait_returns();
            order_check = 1'b0;
        end
        $display("test 4 same-cycle requests: %0d rounds, %0d errors", N_MIX,
                 errors - base_err);

        repeat (20) @(posedge aclk);    // catch stray pulses
        if (wr_bursts != wr_reqs) begin
            proto_errs++;
            $display("%0d write responses seen for %0d write requests", wr_bursts, wr_reqs);
        end
        errors = errors + proto_errs;
        $display("test 5 AXI ports: %0d write bursts, %0d errors", wr_bursts, proto_errs);
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
